// ==== Makefile ====
# Verilator build and run for the MIPS core testbench.

VERILATOR ?= verilator
TOP       ?= tb_top
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Finished with no errors
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/mips_pkg.sv ====
package mips_pkg;

    // Register address and data widths.
    localparam int REG_ADDR_BITS = 5;
    localparam int DATA_BITS     = 32;

    //////////////////////////////////////////////////////////////////////
    // Opcodes.
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    // Function field of R-type.
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    //////////////////////////////////////////////////////////////////////
    // Control encodings.
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        BR_NONE, BR_EQ, BR_NE, BR_JUMP
    } branch_e;

    // One instruction word, seen as R-type or as I/J-type.
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_t;

endpackage

// ==== decode/branch_address_calculator.sv ====
`timescale 1ns/1ps

module branch_address_calculator #(
    parameter int CANT_BITS_ADDR = 11
) (
    input  mips_pkg::branch_e               i_branch_kind,
    input  logic [CANT_BITS_ADDR-1:0]       i_pc,
    input  logic [mips_pkg::DATA_BITS-1:0]  i_data_a,
    input  logic [mips_pkg::DATA_BITS-1:0]  i_data_b,
    input  logic [mips_pkg::DATA_BITS-1:0]  i_imm_ext,
    input  logic [25:0]                     i_instr_index,
    output logic                            o_branch_control,
    output logic [CANT_BITS_ADDR-1:0]       o_branch_dir
);

    logic [CANT_BITS_ADDR-1:0] pc_rel;

    // Relative target wraps at the address width.
    assign pc_rel = i_pc + {{(CANT_BITS_ADDR-1){1'b0}}, 1'b1}
                  + i_imm_ext[CANT_BITS_ADDR-1:0];

    always_comb begin
        o_branch_control = 1'b0;
        o_branch_dir     = pc_rel;
        case (i_branch_kind)
            mips_pkg::BR_EQ:   o_branch_control = (i_data_a == i_data_b);
            mips_pkg::BR_NE:   o_branch_control = (i_data_a != i_data_b);
            mips_pkg::BR_JUMP: begin
                o_branch_control = 1'b1;
                o_branch_dir     = i_instr_index[CANT_BITS_ADDR-1:0];
            end
            default: o_branch_control = 1'b0;
        endcase
    end

endmodule

// ==== decode/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  mips_pkg::instr_t    i_instruction,
    output logic                o_reg_dst_rd,
    output logic                o_reg_write,
    output logic                o_alu_src,
    output logic                o_zero_ext,
    output mips_pkg::alu_ctrl_e o_alu_ctrl,
    output mips_pkg::branch_e   o_branch_kind
);

    always_comb begin
        // Unknown codes fall through as a no-op.
        o_reg_dst_rd  = 1'b0;
        o_reg_write   = 1'b0;
        o_alu_src     = 1'b0;
        o_zero_ext    = 1'b0;
        o_alu_ctrl    = mips_pkg::ALU_ADD;
        o_branch_kind = mips_pkg::BR_NONE;

        case (i_instruction.r.opcode)
            mips_pkg::OP_RTYPE: begin
                o_reg_dst_rd = 1'b1;
                o_reg_write  = 1'b1;
                case (i_instruction.r.funct)
                    mips_pkg::FN_ADDU: o_alu_ctrl = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: o_alu_ctrl = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  o_alu_ctrl = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   o_alu_ctrl = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  o_alu_ctrl = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  o_alu_ctrl = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL:  o_alu_ctrl = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  o_alu_ctrl = mips_pkg::ALU_SRL;
                    default:           o_reg_write = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
            mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                case (i_instruction.i.opcode)
                    mips_pkg::OP_SLTI: o_alu_ctrl = mips_pkg::ALU_SLT;
                    mips_pkg::OP_ANDI: o_alu_ctrl = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:  o_alu_ctrl = mips_pkg::ALU_OR;
                    mips_pkg::OP_XORI: o_alu_ctrl = mips_pkg::ALU_XOR;
                    mips_pkg::OP_LUI:  o_alu_ctrl = mips_pkg::ALU_LUI;
                    default:           o_alu_ctrl = mips_pkg::ALU_ADD;
                endcase
                o_zero_ext = (i_instruction.i.opcode == mips_pkg::OP_ANDI)
                          || (i_instruction.i.opcode == mips_pkg::OP_ORI)
                          || (i_instruction.i.opcode == mips_pkg::OP_XORI);
            end
            mips_pkg::OP_BEQ: o_branch_kind = mips_pkg::BR_EQ;
            mips_pkg::OP_BNE: o_branch_kind = mips_pkg::BR_NE;
            mips_pkg::OP_J:   o_branch_kind = mips_pkg::BR_JUMP;
            default: begin
            end
        endcase
    end

endmodule

// ==== decode/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                                i_clock,
    input  logic                                i_soft_reset,
    input  logic [mips_pkg::REG_ADDR_BITS-1:0]  i_reg_a,
    input  logic [mips_pkg::REG_ADDR_BITS-1:0]  i_reg_b,
    input  logic                                i_write,
    input  logic [mips_pkg::REG_ADDR_BITS-1:0]  i_reg_write,
    input  logic [mips_pkg::DATA_BITS-1:0]      i_data_write,
    output logic [mips_pkg::DATA_BITS-1:0]      o_data_a,
    output logic [mips_pkg::DATA_BITS-1:0]      o_data_b
);

    logic [mips_pkg::DATA_BITS-1:0] regs [2**mips_pkg::REG_ADDR_BITS];

    // Register 0 is hardwired, a same-cycle write passes straight through.
    function automatic logic [mips_pkg::DATA_BITS-1:0] read_port(
        input logic [mips_pkg::REG_ADDR_BITS-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (i_write && (addr == i_reg_write)) begin
            return i_data_write;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            for (int idx = 0; idx < 2**mips_pkg::REG_ADDR_BITS; idx++) begin
                regs[idx] <= '0;
            end
        end else if (i_write && (i_reg_write != '0)) begin
            regs[i_reg_write] <= i_data_write;
        end
    end

    always_comb begin
        o_data_a = read_port(i_reg_a);
        o_data_b = read_port(i_reg_b);
    end

endmodule

// ==== decode/top_id.sv ====
`timescale 1ns/1ps

module top_id #(
    parameter int CANT_BITS_ADDR = 11
) (
    input  logic                                i_clock,
    input  logic                                i_soft_reset,
    input  logic                                i_instr_valid,
    input  logic [31:0]                         i_instruction,
    input  logic [CANT_BITS_ADDR-1:0]           i_pc,
    input  logic                                i_wb_valid,
    input  logic [mips_pkg::REG_ADDR_BITS-1:0]  i_wb_reg,
    input  logic [mips_pkg::DATA_BITS-1:0]      i_wb_data,
    output logic                                o_valid,
    output logic [mips_pkg::DATA_BITS-1:0]      o_data_a,
    output logic [mips_pkg::DATA_BITS-1:0]      o_data_b,
    output logic [mips_pkg::DATA_BITS-1:0]      o_imm_ext,
    output logic [4:0]                          o_shamt,
    output logic [mips_pkg::REG_ADDR_BITS-1:0]  o_reg_dst,
    output logic                                o_alu_src,
    output logic                                o_reg_write,
    output mips_pkg::alu_ctrl_e                 o_alu_ctrl,
    output logic                                o_branch_taken,
    output logic [CANT_BITS_ADDR-1:0]           o_branch_dir
);

    mips_pkg::instr_t                   instr;
    mips_pkg::alu_ctrl_e                alu_ctrl;
    mips_pkg::branch_e                  branch_kind;
    logic                               reg_dst_rd;
    logic                               reg_write;
    logic                               alu_src;
    logic                               zero_ext;
    logic [mips_pkg::DATA_BITS-1:0]     data_a;
    logic [mips_pkg::DATA_BITS-1:0]     data_b;
    logic [mips_pkg::DATA_BITS-1:0]     imm_ext;
    logic [mips_pkg::REG_ADDR_BITS-1:0] reg_dst;
    logic                               branch_control;
    logic [CANT_BITS_ADDR-1:0]          branch_dir;

    assign instr   = i_instruction;
    assign reg_dst = reg_dst_rd ? instr.r.rd : instr.i.rt;

    // Logic immediates zero-extend, the rest sign-extend.
    assign imm_ext = zero_ext
                   ? {{(mips_pkg::DATA_BITS-16){1'b0}}, instr.i.imm}
                   : {{(mips_pkg::DATA_BITS-16){instr.i.imm[15]}}, instr.i.imm};

    control_unit u_control_unit (
        .i_instruction (instr),
        .o_reg_dst_rd  (reg_dst_rd),
        .o_reg_write   (reg_write),
        .o_alu_src     (alu_src),
        .o_zero_ext    (zero_ext),
        .o_alu_ctrl    (alu_ctrl),
        .o_branch_kind (branch_kind)
    );

    register_file u_register_file (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_reg_a      (instr.r.rs),
        .i_reg_b      (instr.r.rt),
        .i_write      (i_wb_valid),
        .i_reg_write  (i_wb_reg),
        .i_data_write (i_wb_data),
        .o_data_a     (data_a),
        .o_data_b     (data_b)
    );

    branch_address_calculator #(
        .CANT_BITS_ADDR (CANT_BITS_ADDR)
    ) u_branch_address_calculator (
        .i_branch_kind    (branch_kind),
        .i_pc             (i_pc),
        .i_data_a         (data_a),
        .i_data_b         (data_b),
        .i_imm_ext        (imm_ext),
        .i_instr_index    (instr.i[25:0]),
        .o_branch_control (branch_control),
        .o_branch_dir     (branch_dir)
    );

    //////////////////////////////////////////////////////////////////////
    // Decode to execute registers.
    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_valid        <= 1'b0;
            o_reg_write    <= 1'b0;
            o_branch_taken <= 1'b0;
        end else begin
            o_valid        <= i_instr_valid;
            o_reg_write    <= reg_write;
            o_branch_taken <= i_instr_valid && branch_control;
        end
    end

    always_ff @(posedge i_clock) begin
        o_data_a     <= data_a;
        o_data_b     <= data_b;
        o_imm_ext    <= imm_ext;
        o_shamt      <= instr.r.shamt;
        o_reg_dst    <= reg_dst;
        o_alu_src    <= alu_src;
        o_alu_ctrl   <= alu_ctrl;
        o_branch_dir <= branch_dir;
    end

endmodule

// ==== list.f ====
common/mips_pkg.sv
decode/control_unit.sv
decode/register_file.sv
decode/branch_address_calculator.sv
decode/top_id.sv
rtl/ex_stage.sv
rtl/top_mips_core.sv
sim/tb_checker.sv
sim/tb_top.sv

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  logic                                i_clock,
    input  logic                                i_soft_reset,
    input  logic                                i_valid,
    input  logic [mips_pkg::DATA_BITS-1:0]      i_data_a,
    input  logic [mips_pkg::DATA_BITS-1:0]      i_data_b,
    input  logic [mips_pkg::DATA_BITS-1:0]      i_imm_ext,
    input  logic [4:0]                          i_shamt,
    input  logic [mips_pkg::REG_ADDR_BITS-1:0]  i_reg_dst,
    input  logic                                i_alu_src,
    input  logic                                i_reg_write,
    input  mips_pkg::alu_ctrl_e                 i_alu_ctrl,
    output logic                                o_wb_valid,
    output logic [mips_pkg::REG_ADDR_BITS-1:0]  o_wb_reg,
    output logic [mips_pkg::DATA_BITS-1:0]      o_wb_data
);

    logic [mips_pkg::DATA_BITS-1:0] op_b;
    logic [mips_pkg::DATA_BITS-1:0] alu_result;

    assign op_b = i_alu_src ? i_imm_ext : i_data_b;

    //////////////////////////////////////////////////////////////////////
    // ALU.
    always_comb begin
        case (i_alu_ctrl)
            mips_pkg::ALU_ADD: alu_result = i_data_a + op_b;
            mips_pkg::ALU_SUB: alu_result = i_data_a - op_b;
            mips_pkg::ALU_AND: alu_result = i_data_a & op_b;
            mips_pkg::ALU_OR:  alu_result = i_data_a | op_b;
            mips_pkg::ALU_XOR: alu_result = i_data_a ^ op_b;
            mips_pkg::ALU_SLT: begin
                alu_result = {{(mips_pkg::DATA_BITS-1){1'b0}},
                              ($signed(i_data_a) < $signed(op_b))};
            end
            mips_pkg::ALU_SLL: alu_result = op_b << i_shamt;
            mips_pkg::ALU_SRL: alu_result = op_b >> i_shamt;
            mips_pkg::ALU_LUI: alu_result = {i_imm_ext[15:0], 16'h0000};
            default:           alu_result = '0;
        endcase
    end

    // Execute to write-back registers.
    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= i_valid && i_reg_write && (i_reg_dst != '0);
        end
    end

    always_ff @(posedge i_clock) begin
        o_wb_reg  <= i_reg_dst;
        o_wb_data <= alu_result;
    end

endmodule

// ==== rtl/top_mips_core.sv ====
`timescale 1ns/1ps

module top_mips_core #(
    parameter int CANT_BITS_ADDR = 11
) (
    input  logic                        i_clock,
    input  logic                        i_soft_reset,
    input  logic                        i_instr_valid,
    input  logic [31:0]                 i_instruction,
    input  logic [CANT_BITS_ADDR-1:0]   i_pc,
    output logic                        o_wb_valid,
    output logic [4:0]                  o_wb_reg,
    output logic [31:0]                 o_wb_data,
    output logic                        o_branch_taken,
    output logic [CANT_BITS_ADDR-1:0]   o_branch_dir
);

    logic                               id_valid;
    logic [mips_pkg::DATA_BITS-1:0]     id_data_a;
    logic [mips_pkg::DATA_BITS-1:0]     id_data_b;
    logic [mips_pkg::DATA_BITS-1:0]     id_imm_ext;
    logic [4:0]                         id_shamt;
    logic [mips_pkg::REG_ADDR_BITS-1:0] id_reg_dst;
    logic                               id_alu_src;
    logic                               id_reg_write;
    mips_pkg::alu_ctrl_e                id_alu_ctrl;
    logic                               ex_wb_valid;
    logic [mips_pkg::REG_ADDR_BITS-1:0] ex_wb_reg;
    logic [mips_pkg::DATA_BITS-1:0]     ex_wb_data;

    top_id #(
        .CANT_BITS_ADDR (CANT_BITS_ADDR)
    ) u_top_id (
        .i_clock        (i_clock),
        .i_soft_reset   (i_soft_reset),
        .i_instr_valid  (i_instr_valid),
        .i_instruction  (i_instruction),
        .i_pc           (i_pc),
        .i_wb_valid     (ex_wb_valid),
        .i_wb_reg       (ex_wb_reg),
        .i_wb_data      (ex_wb_data),
        .o_valid        (id_valid),
        .o_data_a       (id_data_a),
        .o_data_b       (id_data_b),
        .o_imm_ext      (id_imm_ext),
        .o_shamt        (id_shamt),
        .o_reg_dst      (id_reg_dst),
        .o_alu_src      (id_alu_src),
        .o_reg_write    (id_reg_write),
        .o_alu_ctrl     (id_alu_ctrl),
        .o_branch_taken (o_branch_taken),
        .o_branch_dir   (o_branch_dir)
    );

    ex_stage u_ex_stage (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_valid      (id_valid),
        .i_data_a     (id_data_a),
        .i_data_b     (id_data_b),
        .i_imm_ext    (id_imm_ext),
        .i_shamt      (id_shamt),
        .i_reg_dst    (id_reg_dst),
        .i_alu_src    (id_alu_src),
        .i_reg_write  (id_reg_write),
        .i_alu_ctrl   (id_alu_ctrl),
        .o_wb_valid   (ex_wb_valid),
        .o_wb_reg     (ex_wb_reg),
        .o_wb_data    (ex_wb_data)
    );

    // Write-back is also visible outside.
    assign o_wb_valid = ex_wb_valid;
    assign o_wb_reg   = ex_wb_reg;
    assign o_wb_data  = ex_wb_data;

endmodule

// ==== sim/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker #(
    parameter int ADDR_BITS = 11
) (
    input  logic                 i_clock,
    input  logic                 i_soft_reset,
    input  logic                 i_instr_valid,
    input  logic [31:0]          i_instruction,
    input  logic [ADDR_BITS-1:0] i_pc,
    input  logic                 i_wb_valid,
    input  logic [4:0]           i_wb_reg,
    input  logic [31:0]          i_wb_data,
    input  logic                 i_branch_taken,
    input  logic [ADDR_BITS-1:0] i_branch_dir,
    output int                   o_error_count,
    output int                   o_pending
);

    logic [31:0]          model_regs [32];
    logic                 pend_write  = 1'b0;
    logic [4:0]           pend_reg    = '0;
    logic [31:0]          pend_data   = '0;
    logic                 live        = 1'b0;
    int                   cycle_count = 0;
    int                   errors      = 0;
    int                   outstanding = 0;
    int                   wb_due [$];
    logic [4:0]           wb_reg_q [$];
    logic [31:0]          wb_data_q [$];
    int                   br_due [$];
    logic [ADDR_BITS-1:0] br_dir_q [$];

    assign o_error_count = errors;
    assign o_pending     = outstanding;

    //////////////////////////////////////////////////////////////////////
    // Expected outcome of one instruction from the instruction set rules.
    function automatic void predict_instr(
        input  logic [31:0]          word,
        input  logic [ADDR_BITS-1:0] pc,
        input  logic [31:0]          val_a,
        input  logic [31:0]          val_b,
        output logic                 writes,
        output logic [4:0]           dest,
        output logic [31:0]          value,
        output logic                 taken,
        output logic [ADDR_BITS-1:0] target
    );
        mips_pkg::instr_t ins;
        logic [31:0]      sext;
        logic [31:0]      zext;

        ins    = word;
        sext   = {{16{ins.i.imm[15]}}, ins.i.imm};
        zext   = {16'h0000, ins.i.imm};
        writes = 1'b1;
        dest   = ins.i.rt;
        value  = '0;
        taken  = 1'b0;
        target = pc + ADDR_BITS'(1) + sext[ADDR_BITS-1:0];
        case (ins.r.opcode)
            mips_pkg::OP_RTYPE: begin
                dest = ins.r.rd;
                case (ins.r.funct)
                    mips_pkg::FN_ADDU: value = val_a + val_b;
                    mips_pkg::FN_SUBU: value = val_a - val_b;
                    mips_pkg::FN_AND:  value = val_a & val_b;
                    mips_pkg::FN_OR:   value = val_a | val_b;
                    mips_pkg::FN_XOR:  value = val_a ^ val_b;
                    mips_pkg::FN_SLT:  value = ($signed(val_a) < $signed(val_b)) ? 32'd1 : 32'd0;
                    mips_pkg::FN_SLL:  value = val_b << ins.r.shamt;
                    mips_pkg::FN_SRL:  value = val_b >> ins.r.shamt;
                    default:           writes = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: value = val_a + sext;
            mips_pkg::OP_SLTI:  value = ($signed(val_a) < $signed(sext)) ? 32'd1 : 32'd0;
            mips_pkg::OP_ANDI:  value = val_a & zext;
            mips_pkg::OP_ORI:   value = val_a | zext;
            mips_pkg::OP_XORI:  value = val_a ^ zext;
            mips_pkg::OP_LUI:   value = {ins.i.imm, 16'h0000};
            mips_pkg::OP_BEQ: begin
                writes = 1'b0;
                taken  = (val_a == val_b);
            end
            mips_pkg::OP_BNE: begin
                writes = 1'b0;
                taken  = (val_a != val_b);
            end
            mips_pkg::OP_J: begin
                writes = 1'b0;
                taken  = 1'b1;
                target = word[ADDR_BITS-1:0];
            end
            default: writes = 1'b0;
        endcase
        if (dest == 5'd0) begin
            writes = 1'b0;
        end
    endfunction

    // Inputs are sampled on the rising edge, where they are stable.
    always @(posedge i_clock) begin : model_issue
        mips_pkg::instr_t     ins;
        logic                 writes;
        logic [4:0]           dest;
        logic [31:0]          value;
        logic                 taken;
        logic [ADDR_BITS-1:0] target;

        ins  = i_instruction;
        live = i_soft_reset;
        if (!i_soft_reset) begin
            for (int idx = 0; idx < 32; idx++) begin
                model_regs[idx] = '0;
            end
            pend_write = 1'b0;
        end else begin
            writes = 1'b0;
            taken  = 1'b0;
            dest   = '0;
            value  = '0;
            target = '0;
            if (i_instr_valid) begin
                predict_instr(i_instruction, i_pc, model_regs[ins.r.rs], model_regs[ins.r.rt],
                              writes, dest, value, taken, target);
            end
            // The previous strobe's result lands only after this read.
            if (pend_write) begin
                model_regs[pend_reg] = pend_data;
            end
            pend_write = writes;
            pend_reg   = dest;
            pend_data  = value;
            if (writes) begin
                wb_due.push_back(cycle_count + 2);
                wb_reg_q.push_back(dest);
                wb_data_q.push_back(value);
            end
            if (taken) begin
                br_due.push_back(cycle_count + 1);
                br_dir_q.push_back(target);
            end
        end
        cycle_count = cycle_count + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Outputs are compared on the falling edge.
    always @(negedge i_clock) begin : compare_outputs
        if (live) begin
            if (wb_due.size() != 0 && wb_due[0] == cycle_count) begin
                if (i_wb_valid !== 1'b1) begin
                    errors++;
                    $display("Error at time %0t: expected write-back r%0d = %h, got no strobe",
                             $time, wb_reg_q[0], wb_data_q[0]);
                end else if (i_wb_reg !== wb_reg_q[0] || i_wb_data !== wb_data_q[0]) begin
                    errors++;
                    $display("Error at time %0t: write-back expected r%0d = %h, got r%0d = %h",
                             $time, wb_reg_q[0], wb_data_q[0], i_wb_reg, i_wb_data);
                end
                void'(wb_due.pop_front());
                void'(wb_reg_q.pop_front());
                void'(wb_data_q.pop_front());
            end else if (i_wb_valid !== 1'b0) begin
                errors++;
                $display("Write-back strobe at time %0t that no instruction asked for (r%0d = %h)",
                         $time, i_wb_reg, i_wb_data);
            end
            if (br_due.size() != 0 && br_due[0] == cycle_count) begin
                if (i_branch_taken !== 1'b1) begin
                    errors++;
                    $display("Error at time %0t: expected branch to %h, got no strobe",
                             $time, br_dir_q[0]);
                end else if (i_branch_dir !== br_dir_q[0]) begin
                    errors++;
                    $display("Error at time %0t: branch target expected %h, got %h",
                             $time, br_dir_q[0], i_branch_dir);
                end
                void'(br_due.pop_front());
                void'(br_dir_q.pop_front());
            end else if (i_branch_taken !== 1'b0) begin
                errors++;
                $display("Branch strobe at time %0t with no taken branch (target %h)",
                         $time, i_branch_dir);
            end
        end
        outstanding = wb_due.size() + br_due.size();
    end

endmodule

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int ADDR_BITS    = 11;
    localparam int CLK_PERIOD   = 4;
    localparam int LOAD_REGS    = 15;
    localparam int RANDOM_COUNT = 400;
    localparam int INSTR_COUNT  = 2 * LOAD_REGS + RANDOM_COUNT;
    // Each instruction takes at most 4 cycles with gaps and hazard idles.
    localparam int TIMEOUT_NS   = INSTR_COUNT * 4 * CLK_PERIOD + 100 * CLK_PERIOD;

    logic                 clock;
    logic                 soft_reset;
    logic                 instr_valid;
    logic [31:0]          instruction;
    logic [ADDR_BITS-1:0] pc;
    logic                 wb_valid;
    logic [4:0]           wb_reg;
    logic [31:0]          wb_data;
    logic                 branch_taken;
    logic [ADDR_BITS-1:0] branch_dir;
    int                   error_count;
    int                   pending_count;
    logic                 prev_strobe;
    logic [4:0]           prev_dest;

    top_mips_core #(
        .CANT_BITS_ADDR (ADDR_BITS)
    ) i_dut (
        .i_clock        (clock),
        .i_soft_reset   (soft_reset),
        .i_instr_valid  (instr_valid),
        .i_instruction  (instruction),
        .i_pc           (pc),
        .o_wb_valid     (wb_valid),
        .o_wb_reg       (wb_reg),
        .o_wb_data      (wb_data),
        .o_branch_taken (branch_taken),
        .o_branch_dir   (branch_dir)
    );

    tb_checker #(
        .ADDR_BITS (ADDR_BITS)
    ) u_checker (
        .i_clock        (clock),
        .i_soft_reset   (soft_reset),
        .i_instr_valid  (instr_valid),
        .i_instruction  (instruction),
        .i_pc           (pc),
        .i_wb_valid     (wb_valid),
        .i_wb_reg       (wb_reg),
        .i_wb_data      (wb_data),
        .i_branch_taken (branch_taken),
        .i_branch_dir   (branch_dir),
        .o_error_count  (error_count),
        .o_pending      (pending_count)
    );

    initial begin : clock_gen
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers.
    function automatic logic [4:0] write_target(input logic [31:0] word);
        mips_pkg::instr_t ins;

        ins = word;
        if (ins.r.opcode == mips_pkg::OP_RTYPE) begin
            return ins.r.rd;
        end
        if (ins.i.opcode >= mips_pkg::OP_ADDIU && ins.i.opcode <= mips_pkg::OP_LUI) begin
            return ins.i.rt;
        end
        return 5'd0;
    endfunction

    function automatic logic [31:0] random_instruction();
        mips_pkg::instr_t ins;
        int               pick;

        ins      = $urandom;
        ins.r.rs = 5'($urandom_range(0, 15));
        ins.r.rt = 5'($urandom_range(0, 15));
        pick     = $urandom_range(0, 16);
        case (pick)
            0:       ins.r.funct  = mips_pkg::FN_ADDU;
            1:       ins.r.funct  = mips_pkg::FN_SUBU;
            2:       ins.r.funct  = mips_pkg::FN_AND;
            3:       ins.r.funct  = mips_pkg::FN_OR;
            4:       ins.r.funct  = mips_pkg::FN_XOR;
            5:       ins.r.funct  = mips_pkg::FN_SLT;
            6:       ins.r.funct  = mips_pkg::FN_SLL;
            7:       ins.r.funct  = mips_pkg::FN_SRL;
            8:       ins.i.opcode = mips_pkg::OP_ADDIU;
            9:       ins.i.opcode = mips_pkg::OP_SLTI;
            10:      ins.i.opcode = mips_pkg::OP_ANDI;
            11:      ins.i.opcode = mips_pkg::OP_ORI;
            12:      ins.i.opcode = mips_pkg::OP_XORI;
            13:      ins.i.opcode = mips_pkg::OP_LUI;
            14:      ins.i.opcode = mips_pkg::OP_BEQ;
            15:      ins.i.opcode = mips_pkg::OP_BNE;
            default: ins.i.opcode = mips_pkg::OP_J;
        endcase
        if (pick <= 7) begin
            ins.r.opcode = mips_pkg::OP_RTYPE;
            ins.r.rd     = 5'($urandom_range(0, 15));
        end
        return ins;
    endfunction

    // Idle cycles carry a random word so that valid gating is exercised.
    task automatic idle_cycle();
        @(negedge clock);
        instr_valid = 1'b0;
        instruction = random_instruction();
        pc          = ADDR_BITS'($urandom);
        prev_strobe = 1'b0;
    endtask

    task automatic strobe_instruction(input logic [31:0] word);
        mips_pkg::instr_t ins;

        ins = word;
        if (prev_strobe && prev_dest != 5'd0
            && (ins.r.rs == prev_dest || ins.r.rt == prev_dest)) begin
            idle_cycle();
        end
        @(negedge clock);
        instr_valid = 1'b1;
        instruction = word;
        pc          = ADDR_BITS'($urandom);
        prev_strobe = 1'b1;
        prev_dest   = write_target(word);
    endtask

    //////////////////////////////////////////////////////////////////////
    initial begin : stimulus
        void'($urandom(32'hd3e4_bd4a));
        soft_reset  = 1'b0;
        instr_valid = 1'b0;
        instruction = '0;
        pc          = '0;
        prev_strobe = 1'b0;
        prev_dest   = '0;
        repeat (4) @(negedge clock);
        soft_reset = 1'b1;
        repeat (3) idle_cycle();

        // Load phase.
        for (int r = 1; r <= LOAD_REGS; r++) begin
            strobe_instruction({mips_pkg::OP_LUI, 5'd0, 5'(r), 16'($urandom)});
            strobe_instruction({mips_pkg::OP_ORI, 5'(r), 5'(r), 16'($urandom)});
        end

        repeat (RANDOM_COUNT) begin
            strobe_instruction(random_instruction());
            repeat ($urandom_range(0, 2)) idle_cycle();
        end

        // Latency is fixed, so a short drain empties the pipeline.
        repeat (5) idle_cycle();
        @(posedge clock);
        if (pending_count != 0) begin
            $display("Run ended with %0d expected results never seen", pending_count);
        end
        $display("Checks done: %0d errors, %0d results outstanding", error_count, pending_count);
        if (error_count == 0 && pending_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
